// ==== Bender.yml ====
package:
  name: transmit_chain

sources:
  - common/tx_pkg.sv
  - rtl/tx_config.sv
  - awg/awg_player.sv
  - rtl/ramp_gen.sv
  - rtl/channel_mux.sv
  - rtl/dac_prescaler.sv
  - rtl/trigger_manager.sv
  - rtl/transmit_top.sv
  - target: simulation
    files:
      - sim/transmit_top_assertions.sv
      - sim/transmit_top_tb.sv

// ==== awg/awg_player.sv ====
/*
  frame depth is read live during playback, burst count is latched at start
  depth 0 or burst 0 plays nothing, depths above 64 wrap like 64
*/
module awg_player (
  input  logic                  ps_clk,
  input  logic                  rst_n_i,
  input  tx_pkg::tx_cfg_t       cfg_i,
  input  tx_pkg::awg_wr_t       awg_wr_i,
  input  logic                  start_i,
  input  logic                  stop_i,
  output tx_pkg::chan_samples_t samples_o,
  output tx_pkg::chan_flags_t   frame_trig_o
);

  tx_pkg::sample_t mem [tx_pkg::CHANNELS][tx_pkg::AWG_DEPTH];

  tx_pkg::awg_state_e [tx_pkg::CHANNELS-1:0]                state_q;
  logic [tx_pkg::CHANNELS-1:0][tx_pkg::AWG_ADDR_BITS-1:0] addr_q;
  logic [tx_pkg::CHANNELS-1:0][tx_pkg::BURST_BITS-1:0]    burst_q;
  tx_pkg::chan_flags_t                                    last_addr;

  // sample memory, one per channel
  always_ff @(posedge ps_clk) begin
    if (awg_wr_i.valid) begin
      mem[awg_wr_i.chan][awg_wr_i.addr] <= awg_wr_i.sample;
    end
  end

  always_comb begin
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      last_addr[c] = ((tx_pkg::FRAME_BITS'(addr_q[c]) + 1'b1) >= cfg_i.frame_depth[c])
                     || (&addr_q[c]);
    end
  end

  always_ff @(posedge ps_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
        state_q[c]      <= tx_pkg::AWG_IDLE;
        addr_q[c]       <= '0;
        burst_q[c]      <= '0;
        samples_o[c]    <= '0;
        frame_trig_o[c] <= 1'b0;
      end
    end else begin
      for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
        // output follows the state held before this edge
        if (state_q[c] == tx_pkg::AWG_PLAY) begin
          samples_o[c]    <= mem[c][addr_q[c]];
          frame_trig_o[c] <= (addr_q[c] == '0);
        end else begin
          samples_o[c]    <= '0;
          frame_trig_o[c] <= 1'b0;
        end

        if (stop_i) begin
          state_q[c] <= tx_pkg::AWG_IDLE;
        end else if (start_i) begin
          addr_q[c]  <= '0;
          burst_q[c] <= cfg_i.burst_count[c];
          if ((cfg_i.burst_count[c] != '0) && (cfg_i.frame_depth[c] != '0)) begin
            state_q[c] <= tx_pkg::AWG_PLAY;
          end else begin
            state_q[c] <= tx_pkg::AWG_IDLE;
          end
        end else if (state_q[c] == tx_pkg::AWG_PLAY) begin
          if (last_addr[c]) begin
            addr_q[c]  <= '0;
            burst_q[c] <= burst_q[c] - 1'b1;
            // last frame of the burst
            if (burst_q[c] == tx_pkg::BURST_BITS'(1)) begin
              state_q[c] <= tx_pkg::AWG_IDLE;
            end
          end else begin
            addr_q[c] <= addr_q[c] + 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== common/tx_pkg.sv ====
/*
  shared widths, opcodes and config structs for the two-channel transmit chain
  all samples are 16-bit two's complement, one per channel per ps_clk cycle
*/
package tx_pkg;

  localparam int CHANNELS      = 2;
  localparam int CHAN_BITS     = $clog2(CHANNELS);
  localparam int SAMPLE_WIDTH  = 16;
  localparam int PHASE_BITS    = 32;
  localparam int SCALE_WIDTH   = 18;
  localparam int SCALE_FRAC    = 16;
  localparam int OFFSET_WIDTH  = 14;
  localparam int PROD_WIDTH    = SAMPLE_WIDTH + SCALE_WIDTH;
  localparam int SCALED_WIDTH  = PROD_WIDTH - SCALE_FRAC;
  localparam int AWG_DEPTH     = 64;
  localparam int AWG_ADDR_BITS = 6;
  localparam int FRAME_BITS    = AWG_ADDR_BITS + 1;
  localparam int BURST_BITS    = 8;
  localparam int SOURCES       = 3 * CHANNELS;
  localparam int SEL_BITS      = 3;
  localparam int TRIG_BITS     = 2 * CHANNELS;
  // matches channel_mux plus the two prescaler stages
  localparam int TRIG_DELAY    = 3;

  typedef enum logic [2:0] {
    CFG_MUX_SEL      = 3'd0,
    CFG_SCALE_OFFSET = 3'd1,
    CFG_PHASE_INC    = 3'd2,
    CFG_TRIGGER      = 3'd3,
    CFG_AWG_WRITE    = 3'd4,
    CFG_AWG_FRAME    = 3'd5,
    CFG_AWG_START    = 3'd6,
    CFG_AWG_STOP     = 3'd7
  } cfg_op_e;

  typedef enum logic {
    AWG_IDLE = 1'b0,
    AWG_PLAY = 1'b1
  } awg_state_e;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef sample_t [CHANNELS-1:0] chan_samples_t;
  typedef logic [CHANNELS-1:0] chan_flags_t;

  // scale is Q2.16, unity is 18'h10000
  typedef struct packed {
    logic signed [SCALE_WIDTH-1:0]  scale;
    logic signed [OFFSET_WIDTH-1:0] offset;
  } scale_offset_t;

  typedef struct packed {
    logic [CHANNELS-1:0][SEL_BITS-1:0]   mux_sel;
    scale_offset_t [CHANNELS-1:0]        scale_offset;
    logic [CHANNELS-1:0][PHASE_BITS-1:0] phase_inc;
    // awg frame triggers low, triangle wraps high
    logic [TRIG_BITS-1:0]                trig_mask;
    logic [CHANNELS-1:0][FRAME_BITS-1:0] frame_depth;
    logic [CHANNELS-1:0][BURST_BITS-1:0] burst_count;
  } tx_cfg_t;

  typedef struct packed {
    logic                     valid;
    logic [CHAN_BITS-1:0]     chan;
    logic [AWG_ADDR_BITS-1:0] addr;
    sample_t                  sample;
  } awg_wr_t;

endpackage

// ==== files.f ====
common/tx_pkg.sv
rtl/tx_config.sv
awg/awg_player.sv
rtl/ramp_gen.sv
rtl/channel_mux.sv
rtl/dac_prescaler.sv
rtl/trigger_manager.sv
rtl/transmit_top.sv
sim/transmit_top_assertions.sv
sim/transmit_top_tb.sv

// ==== rtl/channel_mux.sv ====
/*
  select 0-1 awg, 2-3 sawtooth, 4-5 triangle, 6-7 give zero
  adds one register stage
*/
module channel_mux (
  input  logic                  ps_clk,
  input  logic                  rst_n_i,
  input  tx_pkg::tx_cfg_t       cfg_i,
  input  tx_pkg::chan_samples_t awg_i,
  input  tx_pkg::chan_samples_t saw_i,
  input  tx_pkg::chan_samples_t tri_i,
  output tx_pkg::chan_samples_t samples_o
);

  tx_pkg::sample_t [tx_pkg::SOURCES-1:0] src;

  // index order matches the select encoding
  assign src = {tri_i, saw_i, awg_i};

  always_ff @(posedge ps_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      samples_o <= '0;
    end else begin
      for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
        if (cfg_i.mux_sel[c] < tx_pkg::SOURCES) begin
          samples_o[c] <= src[cfg_i.mux_sel[c]];
        end else begin
          samples_o[c] <= '0;
        end
      end
    end
  end

endmodule

// ==== rtl/dac_prescaler.sv ====
/*
  out = sat16(((sample * scale) >>> 16) + (offset << 2)), two register stages
  scale and offset are taken live from the config, not pipelined with the data
*/
module dac_prescaler (
  input  logic                  ps_clk,
  input  logic                  rst_n_i,
  input  tx_pkg::tx_cfg_t       cfg_i,
  input  tx_pkg::chan_samples_t samples_i,
  output tx_pkg::chan_samples_t samples_o
);

  logic signed [tx_pkg::PROD_WIDTH-1:0]   product  [tx_pkg::CHANNELS];
  logic signed [tx_pkg::SCALED_WIDTH-1:0] scaled_q [tx_pkg::CHANNELS];
  logic signed [tx_pkg::SCALED_WIDTH:0]   sum      [tx_pkg::CHANNELS];
  tx_pkg::chan_flags_t                    in_range;

  always_comb begin
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      product[c] = $signed(samples_i[c]) * $signed(cfg_i.scale_offset[c].scale);
      sum[c]     = scaled_q[c] + ($signed(cfg_i.scale_offset[c].offset) <<< 2);
      // bits above the sample msb must all match the sign
      in_range[c] = (&sum[c][tx_pkg::SCALED_WIDTH:tx_pkg::SAMPLE_WIDTH-1])
                    || (~|sum[c][tx_pkg::SCALED_WIDTH:tx_pkg::SAMPLE_WIDTH-1]);
    end
  end

  always_ff @(posedge ps_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
        scaled_q[c] <= '0;
      end
      samples_o <= '0;
    end else begin
      for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
        // top bits of the product, same as an arithmetic shift by 16
        scaled_q[c] <= product[c][tx_pkg::PROD_WIDTH-1:tx_pkg::SCALE_FRAC];
        if (in_range[c]) begin
          samples_o[c] <= sum[c][tx_pkg::SAMPLE_WIDTH-1:0];
        end else if (sum[c][tx_pkg::SCALED_WIDTH]) begin
          samples_o[c] <= {1'b1, {(tx_pkg::SAMPLE_WIDTH-1){1'b0}}};
        end else begin
          samples_o[c] <= {1'b0, {(tx_pkg::SAMPLE_WIDTH-1){1'b1}}};
        end
      end
    end
  end

endmodule

// ==== rtl/ramp_gen.sv ====
/*
  one 32-bit phase accumulator per channel feeds both sawtooth and triangle
  a phase-clear pulse zeroes the accumulator on the following edge
*/
module ramp_gen (
  input  logic                  ps_clk,
  input  logic                  rst_n_i,
  input  tx_pkg::tx_cfg_t       cfg_i,
  input  tx_pkg::chan_flags_t   phase_clr_i,
  output tx_pkg::chan_samples_t saw_o,
  output tx_pkg::chan_samples_t tri_o,
  output tx_pkg::chan_flags_t   wrap_o
);

  logic [tx_pkg::CHANNELS-1:0][tx_pkg::PHASE_BITS-1:0] phase_q;
  logic [tx_pkg::CHANNELS-1:0][tx_pkg::PHASE_BITS-1:0] phase_d;
  tx_pkg::chan_flags_t                                 carry;

  // fold the phase below the msb, then flip the top bit for two's complement
  function automatic tx_pkg::sample_t tri_of(input logic [tx_pkg::PHASE_BITS-1:0] ph);
    logic [tx_pkg::SAMPLE_WIDTH-1:0] folded;
    folded = ph[tx_pkg::PHASE_BITS-2 -: tx_pkg::SAMPLE_WIDTH]
             ^ {tx_pkg::SAMPLE_WIDTH{ph[tx_pkg::PHASE_BITS-1]}};
    return {~folded[tx_pkg::SAMPLE_WIDTH-1], folded[tx_pkg::SAMPLE_WIDTH-2:0]};
  endfunction

  always_comb begin
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      if (phase_clr_i[c]) begin
        {carry[c], phase_d[c]} = '0;
      end else begin
        {carry[c], phase_d[c]} = {1'b0, phase_q[c]} + {1'b0, cfg_i.phase_inc[c]};
      end
    end
  end

  always_ff @(posedge ps_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= '0;
      saw_o   <= '0;
      tri_o   <= '0;
      wrap_o  <= '0;
    end else begin
      for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
        phase_q[c] <= phase_d[c];
        saw_o[c]   <= phase_d[c][tx_pkg::PHASE_BITS-1 -: tx_pkg::SAMPLE_WIDTH];
        tri_o[c]   <= tri_of(phase_d[c]);
        // high while the wrapped phase is held
        wrap_o[c]  <= carry[c];
      end
    end
  end

endmodule

// ==== rtl/transmit_top.sv ====
/*
  single clock, no back-pressure, one output word per cycle
  source to dac_data_o latency is 3 cycles, start write to first sample 5
*/
module transmit_top (
  input  logic                         ps_clk,
  input  logic                         rst_n_i,
  input  logic                         cfg_we_i,
  input  tx_pkg::cfg_op_e              cfg_op_i,
  input  logic [tx_pkg::CHAN_BITS-1:0] cfg_chan_i,
  input  logic [31:0]                  cfg_data_i,
  output tx_pkg::chan_samples_t        dac_data_o,
  output logic                         dac_trigger_o
);

  tx_pkg::tx_cfg_t       cfg;
  tx_pkg::awg_wr_t       awg_wr;
  logic                  awg_start;
  logic                  awg_stop;
  tx_pkg::chan_flags_t   phase_clr;
  tx_pkg::chan_samples_t awg_samples;
  tx_pkg::chan_flags_t   awg_trig;
  tx_pkg::chan_samples_t saw_samples;
  tx_pkg::chan_samples_t tri_samples;
  tx_pkg::chan_flags_t   wrap_trig;
  tx_pkg::chan_samples_t mux_samples;

  tx_config tx_config_i (
    .ps_clk      (ps_clk),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_op_i    (cfg_op_i),
    .cfg_chan_i  (cfg_chan_i),
    .cfg_data_i  (cfg_data_i),
    .cfg_o       (cfg),
    .awg_wr_o    (awg_wr),
    .awg_start_o (awg_start),
    .awg_stop_o  (awg_stop),
    .phase_clr_o (phase_clr)
  );

  awg_player awg_player_i (
    .ps_clk       (ps_clk),
    .rst_n_i      (rst_n_i),
    .cfg_i        (cfg),
    .awg_wr_i     (awg_wr),
    .start_i      (awg_start),
    .stop_i       (awg_stop),
    .samples_o    (awg_samples),
    .frame_trig_o (awg_trig)
  );

  ramp_gen ramp_gen_i (
    .ps_clk      (ps_clk),
    .rst_n_i     (rst_n_i),
    .cfg_i       (cfg),
    .phase_clr_i (phase_clr),
    .saw_o       (saw_samples),
    .tri_o       (tri_samples),
    .wrap_o      (wrap_trig)
  );

  channel_mux channel_mux_i (
    .ps_clk    (ps_clk),
    .rst_n_i   (rst_n_i),
    .cfg_i     (cfg),
    .awg_i     (awg_samples),
    .saw_i     (saw_samples),
    .tri_i     (tri_samples),
    .samples_o (mux_samples)
  );

  dac_prescaler dac_prescaler_i (
    .ps_clk    (ps_clk),
    .rst_n_i   (rst_n_i),
    .cfg_i     (cfg),
    .samples_i (mux_samples),
    .samples_o (dac_data_o)
  );

  trigger_manager trigger_manager_i (
    .ps_clk     (ps_clk),
    .rst_n_i    (rst_n_i),
    .cfg_i      (cfg),
    .awg_trig_i (awg_trig),
    .wrap_i     (wrap_trig),
    .trig_o     (dac_trigger_o)
  );

endmodule

// ==== rtl/trigger_manager.sv ====
/*
  mask bits 1:0 select awg frame triggers, bits 3:2 triangle wraps
  output is delayed to line up with dac_data_o
*/
module trigger_manager (
  input  logic                ps_clk,
  input  logic                rst_n_i,
  input  tx_pkg::tx_cfg_t     cfg_i,
  input  tx_pkg::chan_flags_t awg_trig_i,
  input  tx_pkg::chan_flags_t wrap_i,
  output logic                trig_o
);

  logic [tx_pkg::TRIG_DELAY-1:0] trig_pipe_q;
  logic                          trig_now;

  assign trig_now = |({wrap_i, awg_trig_i} & cfg_i.trig_mask);

  always_ff @(posedge ps_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trig_pipe_q <= '0;
    end else begin
      trig_pipe_q <= {trig_pipe_q[tx_pkg::TRIG_DELAY-2:0], trig_now};
    end
  end

  assign trig_o = trig_pipe_q[tx_pkg::TRIG_DELAY-1];

endmodule

// ==== rtl/tx_config.sv ====
/*
  every strobe on cfg_we_i is accepted, there is no ready or read-back
  start and stop act on all channels, the other opcodes on cfg_chan_i only
*/
module tx_config (
  input  logic                        ps_clk,
  input  logic                        rst_n_i,
  input  logic                        cfg_we_i,
  input  tx_pkg::cfg_op_e             cfg_op_i,
  input  logic [tx_pkg::CHAN_BITS-1:0] cfg_chan_i,
  input  logic [31:0]                 cfg_data_i,
  output tx_pkg::tx_cfg_t             cfg_o,
  output tx_pkg::awg_wr_t             awg_wr_o,
  output logic                        awg_start_o,
  output logic                        awg_stop_o,
  output tx_pkg::chan_flags_t         phase_clr_o
);

  tx_pkg::tx_cfg_t cfg_q;

  always_ff @(posedge ps_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q       <= '0;
      awg_wr_o    <= '0;
      awg_start_o <= 1'b0;
      awg_stop_o  <= 1'b0;
      phase_clr_o <= '0;
    end else begin
      // pulses last a single cycle
      awg_wr_o.valid <= 1'b0;
      awg_start_o    <= 1'b0;
      awg_stop_o     <= 1'b0;
      phase_clr_o    <= '0;
      if (cfg_we_i) begin
        case (cfg_op_i)
          tx_pkg::CFG_MUX_SEL: begin
            cfg_q.mux_sel[cfg_chan_i] <= cfg_data_i[tx_pkg::SEL_BITS-1:0];
          end
          tx_pkg::CFG_SCALE_OFFSET: begin
            cfg_q.scale_offset[cfg_chan_i] <= tx_pkg::scale_offset_t'(cfg_data_i);
          end
          tx_pkg::CFG_PHASE_INC: begin
            cfg_q.phase_inc[cfg_chan_i] <= cfg_data_i;
            phase_clr_o[cfg_chan_i]     <= 1'b1;
          end
          tx_pkg::CFG_TRIGGER: begin
            cfg_q.trig_mask <= cfg_data_i[tx_pkg::TRIG_BITS-1:0];
          end
          tx_pkg::CFG_AWG_WRITE: begin
            awg_wr_o.valid  <= 1'b1;
            awg_wr_o.chan   <= cfg_chan_i;
            awg_wr_o.addr   <= cfg_data_i[16 +: tx_pkg::AWG_ADDR_BITS];
            awg_wr_o.sample <= cfg_data_i[tx_pkg::SAMPLE_WIDTH-1:0];
          end
          tx_pkg::CFG_AWG_FRAME: begin
            cfg_q.frame_depth[cfg_chan_i] <= cfg_data_i[tx_pkg::FRAME_BITS-1:0];
            cfg_q.burst_count[cfg_chan_i] <= cfg_data_i[8 +: tx_pkg::BURST_BITS];
          end
          tx_pkg::CFG_AWG_START: begin
            awg_start_o <= 1'b1;
          end
          tx_pkg::CFG_AWG_STOP: begin
            awg_stop_o <= 1'b1;
          end
          default: begin
            awg_stop_o <= 1'b0;
          end
        endcase
      end
    end
  end

  assign cfg_o = cfg_q;

endmodule

// ==== sim/transmit_top_assertions.sv ====
/*
  reset behaviour of the outputs and the awg player burst invariant
  looks into awg_player for its state and burst counter
*/
module transmit_top_assertions (
  input logic                                                  ps_clk,
  input logic                                                  rst_n_i,
  input tx_pkg::chan_samples_t                                 dac_data_i,
  input logic                                                  dac_trigger_i,
  input tx_pkg::awg_state_e [tx_pkg::CHANNELS-1:0]             awg_state_i,
  input logic [tx_pkg::CHANNELS-1:0][tx_pkg::BURST_BITS-1:0]   awg_burst_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;

  trig_low_in_reset: assert property (@(posedge ps_clk) !rst_n_i |-> !dac_trigger_i)
    else begin
      $error("dac_trigger_o high while reset is asserted");
      fail_cnt++;
    end

  // pipeline holds zeros for three edges after release
  data_zero_after_reset: assert property (
    @(posedge ps_clk) $rose(rst_n_i) |-> (dac_data_i == '0) [*3])
    else begin
      $error("dac_data_o not zero right after reset release");
      fail_cnt++;
    end

  for (genvar c = 0; c < tx_pkg::CHANNELS; c++) begin : g_chan
    play_has_burst: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
      !(awg_state_i[c] == tx_pkg::AWG_PLAY && awg_burst_i[c] == '0))
      else begin
        $error("awg player %0d playing with zero burst count", c);
        fail_cnt++;
      end
  end

endmodule

bind transmit_top transmit_top_assertions transmit_top_assertions_i (
  .ps_clk        (ps_clk),
  .rst_n_i       (rst_n_i),
  .dac_data_i    (dac_data_o),
  .dac_trigger_i (dac_trigger_o),
  .awg_state_i   (awg_player_i.state_q),
  .awg_burst_i   (awg_player_i.burst_q)
);

// ==== sim/transmit_top_tb.sv ====
/*
  random configuration sequences checked every cycle against a cycle model
  both sample memories are fully written before any playback starts
*/
module transmit_top_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES   = 8;
  localparam int IDLE_CYCLES    = 20;
  localparam int AWG_CYCLES     = 700;
  localparam int RAMP_CYCLES    = 420;
  localparam int SCALE_CYCLES   = 450;
  localparam int RANDOM_CYCLES  = 2000;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + AWG_CYCLES + RAMP_CYCLES
                                  + SCALE_CYCLES + RANDOM_CYCLES + 500;

  logic                         ps_clk;
  logic                         rst_n_i;
  logic                         cfg_we_i;
  tx_pkg::cfg_op_e              cfg_op_i;
  logic [tx_pkg::CHAN_BITS-1:0] cfg_chan_i;
  logic [31:0]                  cfg_data_i;
  tx_pkg::chan_samples_t        dac_data_o;
  logic                         dac_trigger_o;

  int seed      = 24658;
  int cycle_cnt = 0;

  // model registers and pipeline
  logic [tx_pkg::SEL_BITS-1:0]            m_sel   [tx_pkg::CHANNELS];
  logic signed [tx_pkg::SCALE_WIDTH-1:0]  m_scale [tx_pkg::CHANNELS];
  logic signed [tx_pkg::OFFSET_WIDTH-1:0] m_off   [tx_pkg::CHANNELS];
  logic [31:0]                            m_inc   [tx_pkg::CHANNELS];
  logic [31:0]                            m_phase [tx_pkg::CHANNELS];
  int                                     m_depth [tx_pkg::CHANNELS];
  int                                     m_burst [tx_pkg::CHANNELS];
  int                                     m_addr  [tx_pkg::CHANNELS];
  int                                     m_bcnt  [tx_pkg::CHANNELS];
  int                                     m_scaled[tx_pkg::CHANNELS];
  tx_pkg::awg_state_e                     m_state [tx_pkg::CHANNELS];
  tx_pkg::sample_t                        m_mem   [tx_pkg::CHANNELS][tx_pkg::AWG_DEPTH];
  logic [3:0]                             m_mask;
  logic                                   m_wr_valid;
  logic                                   m_wr_chan;
  int                                     m_wr_addr;
  tx_pkg::sample_t                        m_wr_sample;
  logic                                   m_start;
  logic                                   m_stop;
  tx_pkg::chan_flags_t                    m_clr;
  tx_pkg::chan_samples_t                  m_awg;
  tx_pkg::chan_samples_t                  m_saw;
  tx_pkg::chan_samples_t                  m_tri;
  tx_pkg::chan_samples_t                  m_mux;
  tx_pkg::chan_samples_t                  m_dac;
  tx_pkg::chan_flags_t                    m_ftrig;
  tx_pkg::chan_flags_t                    m_wrap;
  logic [2:0]                             m_trig;

  transmit_top transmit_top_i (
    .ps_clk        (ps_clk),
    .rst_n_i       (rst_n_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_op_i      (cfg_op_i),
    .cfg_chan_i    (cfg_chan_i),
    .cfg_data_i    (cfg_data_i),
    .dac_data_o    (dac_data_o),
    .dac_trigger_o (dac_trigger_o)
  );

  initial begin
    ps_clk = 1'b0;
    forever #4 ps_clk = ~ps_clk;
  end

  function automatic int rand_range(input int lo, input int hi);
    int unsigned r;
    r = $random(seed);
    return lo + int'(r % (hi - lo + 1));
  endfunction

  // scale in 31:14, offset in 13:0
  function automatic logic [31:0] so_word(input logic [17:0] scale, input logic [13:0] offset);
    return {scale, offset};
  endfunction

  function automatic logic [31:0] frame_word(input int depth, input int burst);
    return {16'd0, 8'(burst), 1'b0, 7'(depth)};
  endfunction

  task automatic model_reset();
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      m_sel[c]    = '0;
      m_scale[c]  = '0;
      m_off[c]    = '0;
      m_inc[c]    = '0;
      m_phase[c]  = '0;
      m_depth[c]  = 0;
      m_burst[c]  = 0;
      m_addr[c]   = 0;
      m_bcnt[c]   = 0;
      m_scaled[c] = 0;
      m_state[c]  = tx_pkg::AWG_IDLE;
    end
    m_mask      = '0;
    m_wr_valid  = 1'b0;
    m_wr_chan   = 1'b0;
    m_wr_addr   = 0;
    m_wr_sample = '0;
    m_start     = 1'b0;
    m_stop      = 1'b0;
    m_clr       = '0;
    m_awg       = '0;
    m_saw       = '0;
    m_tri       = '0;
    m_mux       = '0;
    m_dac       = '0;
    m_ftrig     = '0;
    m_wrap      = '0;
    m_trig      = '0;
  endtask

  // one clock edge with output stages first so every stage reads the old values
  task automatic model_step();
    longint      prod;
    int          sum;
    logic [32:0] acc;
    logic [15:0] fold;
    m_trig = {m_trig[1:0], |({m_wrap, m_ftrig} & m_mask)};
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      sum = m_scaled[c] + 4 * int'(m_off[c]);
      if (sum > 32767) begin
        sum = 32767;
      end else if (sum < -32768) begin
        sum = -32768;
      end
      m_dac[c]    = tx_pkg::sample_t'(sum);
      prod        = longint'(m_mux[c]) * longint'(m_scale[c]);
      m_scaled[c] = int'(prod >>> 16);
      case (m_sel[c])
        3'd0, 3'd1: m_mux[c] = m_awg[m_sel[c][0]];
        3'd2, 3'd3: m_mux[c] = m_saw[m_sel[c][0]];
        3'd4, 3'd5: m_mux[c] = m_tri[m_sel[c][0]];
        default:    m_mux[c] = '0;
      endcase
    end
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      if (m_state[c] == tx_pkg::AWG_PLAY) begin
        m_awg[c]   = m_mem[c][m_addr[c]];
        m_ftrig[c] = (m_addr[c] == 0);
      end else begin
        m_awg[c]   = '0;
        m_ftrig[c] = 1'b0;
      end
      if (m_stop) begin
        m_state[c] = tx_pkg::AWG_IDLE;
      end else if (m_start) begin
        m_addr[c] = 0;
        m_bcnt[c] = m_burst[c];
        if (m_burst[c] != 0 && m_depth[c] != 0) begin
          m_state[c] = tx_pkg::AWG_PLAY;
        end else begin
          m_state[c] = tx_pkg::AWG_IDLE;
        end
      end else if (m_state[c] == tx_pkg::AWG_PLAY) begin
        if (m_addr[c] + 1 >= m_depth[c]) begin
          m_addr[c] = 0;
          if (m_bcnt[c] == 1) begin
            m_state[c] = tx_pkg::AWG_IDLE;
          end
          m_bcnt[c] = m_bcnt[c] - 1;
        end else begin
          m_addr[c] = m_addr[c] + 1;
        end
      end
      // accumulator with carry out that a phase write clears
      if (m_clr[c]) begin
        acc = '0;
      end else begin
        acc = {1'b0, m_phase[c]} + {1'b0, m_inc[c]};
      end
      m_phase[c] = acc[31:0];
      m_saw[c]   = acc[31:16];
      fold       = acc[30:15];
      if (acc[31]) begin
        fold = ~fold;
      end
      m_tri[c]  = {~fold[15], fold[14:0]};
      m_wrap[c] = acc[32];
    end
    if (m_wr_valid) begin
      m_mem[m_wr_chan][m_wr_addr] = m_wr_sample;
    end
    m_wr_valid = 1'b0;
    m_start    = 1'b0;
    m_stop     = 1'b0;
    m_clr      = '0;
    if (cfg_we_i) begin
      case (cfg_op_i)
        tx_pkg::CFG_MUX_SEL: m_sel[cfg_chan_i] = cfg_data_i[2:0];
        tx_pkg::CFG_SCALE_OFFSET: begin
          m_scale[cfg_chan_i] = cfg_data_i[31:14];
          m_off[cfg_chan_i]   = cfg_data_i[13:0];
        end
        tx_pkg::CFG_PHASE_INC: begin
          m_inc[cfg_chan_i] = cfg_data_i;
          m_clr[cfg_chan_i] = 1'b1;
        end
        tx_pkg::CFG_TRIGGER: m_mask = cfg_data_i[3:0];
        tx_pkg::CFG_AWG_WRITE: begin
          m_wr_valid  = 1'b1;
          m_wr_chan   = cfg_chan_i;
          m_wr_addr   = cfg_data_i[21:16];
          m_wr_sample = cfg_data_i[15:0];
        end
        tx_pkg::CFG_AWG_FRAME: begin
          m_depth[cfg_chan_i] = cfg_data_i[6:0];
          m_burst[cfg_chan_i] = cfg_data_i[15:8];
        end
        tx_pkg::CFG_AWG_START: m_start = 1'b1;
        default: m_stop = 1'b1;
      endcase
    end
  endtask

  always @(posedge ps_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      model_reset();
    end else begin
      model_step();
    end
  end

  task automatic check_samples(input tx_pkg::chan_samples_t exp,
                               input tx_pkg::chan_samples_t got);
    if (got !== exp) begin
      $display("** Error at %0t ns: dac_data_o expected %h %h, got %h %h",
               $time, exp[1], exp[0], got[1], got[0]);
      $display("Simulation FAILED");
      $fatal(1, "dac_data_o mismatch");
    end
  endtask

  task automatic check_trigger(input logic exp, input logic got);
    if (got !== exp) begin
      $display("** Error at %0t ns: dac_trigger_o expected %b, got %b", $time, exp, got);
      $display("Simulation FAILED");
      $fatal(1, "dac_trigger_o mismatch");
    end
  endtask

  // outputs are settled at the falling edge
  always @(negedge ps_clk) begin
    check_samples(m_dac, dac_data_o);
    check_trigger(m_trig[2], dac_trigger_o);
    if (transmit_top_i.transmit_top_assertions_i.fail_cnt != 0) begin
      $display("Assertion failed at %0t ns, the bound checker reported an error", $time);
      $display("Simulation FAILED");
      $fatal(1, "assertion failure");
    end
  end

  always @(posedge ps_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run hung, %0d cycles passed without reaching the end", cycle_cnt);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic drive_write(input tx_pkg::cfg_op_e op, input int chan, input logic [31:0] data);
    @(posedge ps_clk);
    cfg_we_i   <= 1'b1;
    cfg_op_i   <= op;
    cfg_chan_i <= tx_pkg::CHAN_BITS'(chan);
    cfg_data_i <= data;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge ps_clk);
      cfg_we_i <= 1'b0;
    end
  endtask

  task automatic wait_awg_idle();
    do begin
      idle_cycles(1);
      @(negedge ps_clk);
    end while (m_state[0] != tx_pkg::AWG_IDLE || m_state[1] != tx_pkg::AWG_IDLE);
    idle_cycles(8);
  endtask

  task automatic random_write();
    tx_pkg::cfg_op_e op;
    int              chan;
    logic [31:0]     data;
    op   = tx_pkg::cfg_op_e'(rand_range(0, 7));
    chan = rand_range(0, tx_pkg::CHANNELS - 1);
    data = $random(seed);
    // frames stay inside the memory and bursts stay short
    if (op == tx_pkg::CFG_AWG_FRAME) begin
      data = frame_word(rand_range(1, tx_pkg::AWG_DEPTH), rand_range(0, 3));
    end
    drive_write(op, chan, data);
  endtask

  task automatic awg_phase();
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      drive_write(tx_pkg::CFG_MUX_SEL, c, c);
      drive_write(tx_pkg::CFG_SCALE_OFFSET, c, so_word(18'h10000, 14'd0));
      for (int a = 0; a < tx_pkg::AWG_DEPTH; a++) begin
        drive_write(tx_pkg::CFG_AWG_WRITE, c, {10'd0, 6'(a), 16'($random(seed))});
      end
      drive_write(tx_pkg::CFG_AWG_FRAME, c, frame_word(rand_range(1, 24), rand_range(1, 3)));
    end
    drive_write(tx_pkg::CFG_TRIGGER, 0, 32'h1);
    drive_write(tx_pkg::CFG_AWG_START, 0, 32'd0);
    idle_cycles(1);
    wait_awg_idle();
    // long burst that is stopped part-way
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      drive_write(tx_pkg::CFG_AWG_FRAME, c, frame_word(20, 5));
    end
    drive_write(tx_pkg::CFG_AWG_START, 0, 32'd0);
    idle_cycles(30);
    drive_write(tx_pkg::CFG_AWG_STOP, 0, 32'd0);
    idle_cycles(1);
    wait_awg_idle();
  endtask

  task automatic ramp_phase();
    drive_write(tx_pkg::CFG_TRIGGER, 0, 32'hc);
    drive_write(tx_pkg::CFG_MUX_SEL, 0, 3);
    drive_write(tx_pkg::CFG_MUX_SEL, 1, 4);
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      drive_write(tx_pkg::CFG_PHASE_INC, c, $random(seed));
    end
    idle_cycles(200);
    drive_write(tx_pkg::CFG_MUX_SEL, 0, 5);
    drive_write(tx_pkg::CFG_MUX_SEL, 1, 2);
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      drive_write(tx_pkg::CFG_PHASE_INC, c, $random(seed));
    end
    idle_cycles(200);
  endtask

  task automatic scale_phase();
    drive_write(tx_pkg::CFG_MUX_SEL, 0, 2);
    drive_write(tx_pkg::CFG_MUX_SEL, 1, 3);
    // first two trials drive both rails hard
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      drive_write(tx_pkg::CFG_SCALE_OFFSET, c, so_word(18'h1ffff, 14'h1fff));
    end
    idle_cycles(40);
    for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
      drive_write(tx_pkg::CFG_SCALE_OFFSET, c, so_word(18'h20000, 14'h2000));
    end
    idle_cycles(40);
    for (int t = 0; t < 8; t++) begin
      for (int c = 0; c < tx_pkg::CHANNELS; c++) begin
        drive_write(tx_pkg::CFG_SCALE_OFFSET, c, $random(seed));
      end
      idle_cycles(40);
    end
  endtask

  initial begin
    model_reset();
    rst_n_i    = 1'b1;
    cfg_we_i   = 1'b0;
    cfg_op_i   = tx_pkg::CFG_MUX_SEL;
    cfg_chan_i = '0;
    cfg_data_i = '0;
    #1 rst_n_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge ps_clk);
    rst_n_i <= 1'b1;
    idle_cycles(IDLE_CYCLES);
    awg_phase();
    ramp_phase();
    scale_phase();
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      if (rand_range(0, 3) == 0) begin
        random_write();
      end else begin
        idle_cycles(1);
      end
    end
    idle_cycles(8);
    if (transmit_top_i.transmit_top_assertions_i.fail_cnt == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("** Error at %0t ns: %0d assertion failures", $time,
               transmit_top_i.transmit_top_assertions_i.fail_cnt);
      $display("Simulation FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule
